/* design/ooo_consts.svh */
// ------------------------------
// Back end constants
// Data width, register count and
// re-order buffer sizing
// ------------------------------
`ifndef OOO_CONSTS_SVH
`define OOO_CONSTS_SVH

// Data words and instruction addresses
`define OOO_DATA_WIDTH 32
// Architectural registers, 4-bit index
`define OOO_NUM_REGS 16
// Wrap bit on top of the slot bits
`define OOO_TAG_WIDTH 4
// Entries in the re-order buffer
`define OOO_ROB_DEPTH (1 << (`OOO_TAG_WIDTH - 1))

`endif

/* design/ooo_pkg.sv */
// ------------------------------
// Back end package
// Operation codes and the structs
// passed between the blocks
// ------------------------------
`default_nettype none
`include "ooo_consts.svh"

package ooo_pkg;

    typedef logic [`OOO_DATA_WIDTH-1:0]       data_t;
    typedef logic [$clog2(`OOO_NUM_REGS)-1:0] reg_idx_t;
    typedef logic [`OOO_TAG_WIDTH-1:0]        tag_t;

    // Memory classes are reserved
    typedef enum logic [1:0] {OP_INT, OP_BR, OP_LD, OP_ST} op_t;

    typedef enum logic [1:0] {FUNC_ADD, FUNC_SUB, FUNC_AND, FUNC_XOR} alu_func_t;

    typedef struct packed {
        op_t       op;
        alu_func_t func;
        reg_idx_t  rd;
        reg_idx_t  rs1;
        reg_idx_t  rs2;
        logic      use_imm;
        data_t     imm;
        data_t     iaddr;
    } instr_t;

    typedef struct packed {
        logic      valid;
        op_t       op;
        alu_func_t func;
        logic      use_imm;
        data_t     opa;
        data_t     opb;
        data_t     imm;
        data_t     iaddr;
        tag_t      tag;
    } issue_t;

    // exc marks a taken branch
    typedef struct packed {
        logic  en;
        tag_t  tag;
        data_t data;
        logic  exc;
    } cdb_t;

    typedef struct packed {
        logic     en;
        logic     wr_en;
        reg_idx_t rd;
        data_t    data;
        tag_t     tag;
    } commit_t;

    typedef struct packed {
        logic  en;
        data_t target;
    } redirect_t;

    typedef struct packed {
        logic     en;
        op_t      op;
        reg_idx_t rd;
    } rob_alloc_t;

endpackage

`default_nettype wire

/* design/reorder_buffer.sv */
// ------------------------------
// Re-order buffer
// Holds in-flight results, commits
// in order, flushes on taken branch
// ------------------------------
`default_nettype none
`include "ooo_consts.svh"

module reorder_buffer (
    input  wire                        clk,
    input  wire                        n_rst,
    // Allocation from dispatch
    input  wire ooo_pkg::rob_alloc_t   i_alloc,
    output ooo_pkg::tag_t              o_alloc_tag,
    output logic                       o_full,
    // Result writeback
    input  wire ooo_pkg::cdb_t         i_cdb,
    // Source operand lookup
    input  wire ooo_pkg::tag_t         i_lookup_tag [2],
    output logic                       o_lookup_rdy [2],
    output ooo_pkg::data_t             o_lookup_data [2],
    // Retirement and flush
    output ooo_pkg::commit_t           o_commit,
    output ooo_pkg::redirect_t         o_redirect
);
    import ooo_pkg::*;

    localparam int SLOT_W = `OOO_TAG_WIDTH - 1;

    // Entry storage, ready bits are control state
    logic [`OOO_ROB_DEPTH-1:0] rob_rdy;
    logic                      rob_exc  [`OOO_ROB_DEPTH];
    op_t                       rob_op   [`OOO_ROB_DEPTH];
    reg_idx_t                  rob_rd   [`OOO_ROB_DEPTH];
    data_t                     rob_data [`OOO_ROB_DEPTH];

    // Allocate at head, retire at tail
    tag_t head;
    tag_t tail;

    logic [SLOT_W-1:0] head_slot;
    logic [SLOT_W-1:0] tail_slot;
    logic [SLOT_W-1:0] cdb_slot;

    logic empty;
    logic alloc_fire;
    logic tail_rdy;
    logic tail_taken;
    logic commit_fire;

    assign head_slot = head[SLOT_W-1:0];
    assign tail_slot = tail[SLOT_W-1:0];
    assign cdb_slot  = i_cdb.tag[SLOT_W-1:0];

    // Same slot, wrap bits equal means empty, different means full
    assign empty  = (head == tail);
    assign o_full = (head == {~tail[`OOO_TAG_WIDTH-1], tail[SLOT_W-1:0]});

    assign alloc_fire  = i_alloc.en && !o_full;
    assign o_alloc_tag = head;

    // Tail entry state
    assign tail_rdy    = !empty && rob_rdy[tail_slot];
    assign tail_taken  = tail_rdy && rob_exc[tail_slot] && (rob_op[tail_slot] == OP_BR);
    assign commit_fire = tail_rdy && !tail_taken;

    // Operand lookup, bus result takes priority over stored entry
    for (genvar i = 0; i < 2; i++) begin : g_lookup
        logic                 cdb_hit;
        logic [SLOT_W-1:0]    lk_slot;

        assign lk_slot          = i_lookup_tag[i][SLOT_W-1:0];
        assign cdb_hit          = i_cdb.en && (i_cdb.tag == i_lookup_tag[i]);
        assign o_lookup_rdy[i]  = cdb_hit || rob_rdy[lk_slot];
        assign o_lookup_data[i] = cdb_hit ? i_cdb.data : rob_data[lk_slot];
    end

    // Head-of-line commit, register write for integer ops only
    always_comb begin
        o_commit.en    = commit_fire;
        o_commit.wr_en = commit_fire && (rob_op[tail_slot] == OP_INT);
        o_commit.rd    = rob_rd[tail_slot];
        o_commit.data  = rob_data[tail_slot];
        o_commit.tag   = tail;
    end

    // Taken branch at tail, stored data is the target
    always_comb begin
        o_redirect.en     = tail_taken;
        o_redirect.target = rob_data[tail_slot];
    end

    // Pointers
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            head <= '0;
            tail <= '0;
        end else if (tail_taken) begin
            // Drop the branch and everything younger
            head <= tail + tag_t'(1);
            tail <= tail + tag_t'(1);
        end else begin
            if (alloc_fire) begin
                head <= head + tag_t'(1);
            end
            if (commit_fire) begin
                tail <= tail + tag_t'(1);
            end
        end
    end

    // Ready bits, cleared on allocation and set by the bus
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            rob_rdy <= '0;
        end else begin
            if (alloc_fire) begin
                rob_rdy[head_slot] <= 1'b0;
            end
            if (i_cdb.en) begin
                rob_rdy[cdb_slot] <= 1'b1;
            end
        end
    end

    // Entry payload
    always_ff @(posedge clk) begin
        if (alloc_fire) begin
            rob_exc[head_slot] <= 1'b0;
            rob_op[head_slot]  <= i_alloc.op;
            rob_rd[head_slot]  <= i_alloc.rd;
        end
        // Bus never targets the slot being allocated
        if (i_cdb.en) begin
            rob_exc[cdb_slot]  <= i_cdb.exc;
            rob_data[cdb_slot] <= i_cdb.data;
        end
    end

endmodule

`default_nettype wire

/* design/rename_dispatch.sv */
// ------------------------------
// Rename and dispatch
// Register file, rename table,
// operand resolution and issue
// ------------------------------
`default_nettype none
`include "ooo_consts.svh"

module rename_dispatch (
    input  wire                        clk,
    input  wire                        n_rst,
    input  wire ooo_pkg::instr_t       i_instr,
    input  wire                        i_instr_valid,
    output logic                       o_stall,
    // Re-order buffer allocation
    output ooo_pkg::rob_alloc_t        o_alloc,
    input  wire ooo_pkg::tag_t         i_alloc_tag,
    input  wire                        i_rob_full,
    // Operand lookup
    output ooo_pkg::tag_t              o_lookup_tag [2],
    input  wire                        i_lookup_rdy [2],
    input  wire ooo_pkg::data_t        i_lookup_data [2],
    input  wire ooo_pkg::cdb_t         i_cdb,
    input  wire ooo_pkg::commit_t      i_commit,
    input  wire ooo_pkg::redirect_t    i_redirect,
    output ooo_pkg::issue_t            o_issue
);
    import ooo_pkg::*;

    // Architectural state and rename table
    data_t                   regs    [`OOO_NUM_REGS];
    tag_t                    reg_tag [`OOO_NUM_REGS];
    logic [`OOO_NUM_REGS-1:0] busy;

    reg_idx_t src_idx  [2];
    logic     src_rdy  [2];
    data_t    src_data [2];

    logic need_rs2;
    logic srcs_ok;
    logic accept;
    logic has_rd;
    logic commit_wr;

    assign src_idx[0] = i_instr.rs1;
    assign src_idx[1] = i_instr.rs2;

    // Branches compare both sources, immediates replace rs2
    assign need_rs2  = (i_instr.op == OP_BR) || !i_instr.use_imm;
    assign has_rd    = (i_instr.op == OP_INT);
    assign commit_wr = i_commit.en && i_commit.wr_en;

    for (genvar i = 0; i < 2; i++) begin : g_src
        assign o_lookup_tag[i] = reg_tag[src_idx[i]];

        // Register file, then commit, then bus, then buffer
        always_comb begin
            if (!busy[src_idx[i]]) begin
                src_rdy[i]  = 1'b1;
                src_data[i] = regs[src_idx[i]];
            end else if (commit_wr && (i_commit.tag == reg_tag[src_idx[i]])) begin
                src_rdy[i]  = 1'b1;
                src_data[i] = i_commit.data;
            end else if (i_cdb.en && (i_cdb.tag == reg_tag[src_idx[i]])) begin
                src_rdy[i]  = 1'b1;
                src_data[i] = i_cdb.data;
            end else begin
                src_rdy[i]  = i_lookup_rdy[i];
                src_data[i] = i_lookup_data[i];
            end
        end
    end

    assign srcs_ok = src_rdy[0] && (src_rdy[1] || !need_rs2);

    // No reservation station, so wait here for operands
    assign o_stall = i_rob_full || i_redirect.en || (i_instr_valid && !srcs_ok);
    assign accept  = i_instr_valid && !o_stall;

    always_comb begin
        o_alloc.en = accept;
        o_alloc.op = i_instr.op;
        o_alloc.rd = i_instr.rd;
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            for (int r = 0; r < `OOO_NUM_REGS; r++) begin
                regs[r]    <= '0;
                reg_tag[r] <= '0;
            end
            busy <= '0;
        end else begin
            // Retired value always lands, even if renamed again since
            if (commit_wr) begin
                regs[i_commit.rd] <= i_commit.data;
            end
            if (i_redirect.en) begin
                busy <= '0;
            end else begin
                if (commit_wr && (reg_tag[i_commit.rd] == i_commit.tag)) begin
                    busy[i_commit.rd] <= 1'b0;
                end
                // New producer overrides a clear on the same register
                if (accept && has_rd) begin
                    busy[i_instr.rd]    <= 1'b1;
                    reg_tag[i_instr.rd] <= i_alloc_tag;
                end
            end
        end
    end

    // Issue register, valid only in the cycle after acceptance
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            o_issue <= '0;
        end else if (accept) begin
            o_issue <= '{valid:   1'b1,
                         op:      i_instr.op,
                         func:    i_instr.func,
                         use_imm: i_instr.use_imm,
                         opa:     src_data[0],
                         opb:     src_data[1],
                         imm:     i_instr.imm,
                         iaddr:   i_instr.iaddr,
                         tag:     i_alloc_tag};
        end else begin
            o_issue.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* design/alu_branch_unit.sv */
// ------------------------------
// Integer and branch unit
// Two stages, result goes out on
// the common data bus
// ------------------------------
`default_nettype none

module alu_branch_unit (
    input  wire                        clk,
    input  wire                        n_rst,
    input  wire ooo_pkg::issue_t       i_issue,
    input  wire ooo_pkg::redirect_t    i_redirect,
    output ooo_pkg::cdb_t              o_cdb
);
    import ooo_pkg::*;

    data_t opb_sel;
    data_t result;
    logic  taken;

    // Stage one result, held in bus format
    cdb_t  s1_q;

    assign opb_sel = i_issue.use_imm ? i_issue.imm : i_issue.opb;

    always_comb begin
        taken = 1'b0;
        if (i_issue.op == OP_BR) begin
            // Equal sources means taken, predicted not taken
            result = i_issue.iaddr + i_issue.imm;
            taken  = (i_issue.opa == i_issue.opb);
        end else begin
            case (i_issue.func)
                FUNC_ADD: result = i_issue.opa + opb_sel;
                FUNC_SUB: result = i_issue.opa - opb_sel;
                FUNC_AND: result = i_issue.opa & opb_sel;
                default:  result = i_issue.opa ^ opb_sel;
            endcase
        end
    end

    // Flush kills whatever is in either stage
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            s1_q  <= '0;
            o_cdb <= '0;
        end else begin
            s1_q.en   <= i_issue.valid && !i_redirect.en;
            s1_q.tag  <= i_issue.tag;
            s1_q.data <= result;
            s1_q.exc  <= taken;

            o_cdb.en   <= s1_q.en && !i_redirect.en;
            o_cdb.tag  <= s1_q.tag;
            o_cdb.data <= s1_q.data;
            o_cdb.exc  <= s1_q.exc;
        end
    end

endmodule

`default_nettype wire

/* design/ooo_core.sv */
// ------------------------------
// Out-of-order back end top
// Dispatch, execute, re-order
// ------------------------------
`default_nettype none

module ooo_core (
    input  wire                        clk,
    input  wire                        n_rst,
    input  wire ooo_pkg::instr_t       i_instr,
    input  wire                        i_instr_valid,
    output logic                       o_stall,
    output ooo_pkg::commit_t           o_commit,
    output ooo_pkg::redirect_t         o_redirect
);
    import ooo_pkg::*;

    // Dispatch to buffer
    rob_alloc_t alloc;
    tag_t       alloc_tag;
    logic       rob_full;
    tag_t       lookup_tag [2];
    logic       lookup_rdy [2];
    data_t      lookup_data [2];

    // Execute path
    issue_t     issue;
    cdb_t       cdb;

    reorder_buffer reorder_buffer_i (
        .clk           (clk),
        .n_rst         (n_rst),
        .i_alloc       (alloc),
        .o_alloc_tag   (alloc_tag),
        .o_full        (rob_full),
        .i_cdb         (cdb),
        .i_lookup_tag  (lookup_tag),
        .o_lookup_rdy  (lookup_rdy),
        .o_lookup_data (lookup_data),
        .o_commit      (o_commit),
        .o_redirect    (o_redirect)
    );

    rename_dispatch rename_dispatch_i (
        .clk           (clk),
        .n_rst         (n_rst),
        .i_instr       (i_instr),
        .i_instr_valid (i_instr_valid),
        .o_stall       (o_stall),
        .o_alloc       (alloc),
        .i_alloc_tag   (alloc_tag),
        .i_rob_full    (rob_full),
        .o_lookup_tag  (lookup_tag),
        .i_lookup_rdy  (lookup_rdy),
        .i_lookup_data (lookup_data),
        .i_cdb         (cdb),
        .i_commit      (o_commit),
        .i_redirect    (o_redirect),
        .o_issue       (issue)
    );

    alu_branch_unit alu_branch_unit_i (
        .clk        (clk),
        .n_rst      (n_rst),
        .i_issue    (issue),
        .i_redirect (o_redirect),
        .o_cdb      (cdb)
    );

endmodule

`default_nettype wire

/* bench/ooo_core_tb.sv */
// ------------------------------
// Back end testbench
// Runs a short program through the
// core against a sequential model
// ------------------------------
`default_nettype none
`include "ooo_consts.svh"

module ooo_core_tb;
    import ooo_pkg::*;

    localparam int NUM_INSTR      = 17;
    localparam int MAX_EXPECT     = 32;
    localparam int TIMEOUT_CYCLES = 2000;
    localparam int DRAIN_CYCLES   = 12;

    logic      clk;
    logic      n_rst;
    instr_t    instr;
    logic      instr_valid;
    logic      stall;
    commit_t   commit;
    redirect_t redirect;

    // Program table and expected results from the model
    instr_t   prog       [NUM_INSTR];
    logic     exp_wr     [MAX_EXPECT];
    reg_idx_t exp_rd     [MAX_EXPECT];
    data_t    exp_data   [MAX_EXPECT];
    data_t    exp_target [MAX_EXPECT];
    data_t    model_regs [`OOO_NUM_REGS];
    int       exp_commits;
    int       exp_redirects;

    // Run state
    int          errors;
    int          commits_seen;
    int          redirects_seen;
    int          stall_cycles;
    int          fetch_idx;
    int          cycles;
    logic        seen_accept;
    logic        seen_redirect;
    data_t       seen_target;
    logic [31:0] rng;
    // Tags retire in allocation order
    tag_t        exp_tag;

    ooo_core ooo_core_i (
        .clk           (clk),
        .n_rst         (n_rst),
        .i_instr       (instr),
        .i_instr_valid (instr_valid),
        .o_stall       (stall),
        .o_commit      (commit),
        .o_redirect    (redirect)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic instr_t make_instr(input op_t op, input alu_func_t func, input int rd,
                                          input int rs1, input int rs2, input logic use_imm,
                                          input data_t imm, input int idx);
        instr_t t;
        t.op      = op;
        t.func    = func;
        t.rd      = reg_idx_t'(rd);
        t.rs1     = reg_idx_t'(rs1);
        t.rs2     = reg_idx_t'(rs2);
        t.use_imm = use_imm;
        t.imm     = imm;
        t.iaddr   = data_t'(idx * 4);
        return t;
    endfunction

    task automatic load_program();
        // Build values from r0
        prog[0]  = make_instr(OP_INT, FUNC_ADD, 1, 0, 0, 1'b1, 32'd5, 0);
        prog[1]  = make_instr(OP_INT, FUNC_ADD, 2, 0, 0, 1'b1, 32'd12, 1);
        // Back-to-back dependent chain through all four functions
        prog[2]  = make_instr(OP_INT, FUNC_ADD, 3, 1, 2, 1'b0, 32'd0, 2);
        prog[3]  = make_instr(OP_INT, FUNC_SUB, 4, 3, 1, 1'b0, 32'd0, 3);
        prog[4]  = make_instr(OP_INT, FUNC_AND, 5, 4, 2, 1'b0, 32'd0, 4);
        prog[5]  = make_instr(OP_INT, FUNC_XOR, 6, 5, 3, 1'b0, 32'd0, 5);
        // Falls through since r1 != r2
        prog[6]  = make_instr(OP_BR,  FUNC_ADD, 0, 1, 2, 1'b0, 32'd8, 6);
        // Taken as r4 == r2
        // Jumps from 28 to 40 over two entries
        prog[7]  = make_instr(OP_BR,  FUNC_ADD, 0, 4, 2, 1'b0, 32'd12, 7);
        prog[8]  = make_instr(OP_INT, FUNC_ADD, 7, 0, 0, 1'b1, 32'd99, 8);
        prog[9]  = make_instr(OP_INT, FUNC_ADD, 8, 0, 0, 1'b1, 32'd77, 9);
        // Mostly independent run at the end
        prog[10] = make_instr(OP_INT, FUNC_ADD, 9, 0, 0, 1'b1, 32'h100, 10);
        prog[11] = make_instr(OP_INT, FUNC_ADD, 10, 0, 0, 1'b1, 32'h200, 11);
        prog[12] = make_instr(OP_INT, FUNC_SUB, 11, 0, 0, 1'b1, 32'd3, 12);
        prog[13] = make_instr(OP_INT, FUNC_ADD, 1, 1, 0, 1'b1, 32'd1, 13);
        prog[14] = make_instr(OP_INT, FUNC_XOR, 12, 0, 0, 1'b1, 32'h55, 14);
        prog[15] = make_instr(OP_INT, FUNC_ADD, 13, 9, 10, 1'b0, 32'd0, 15);
        prog[16] = make_instr(OP_INT, FUNC_XOR, 14, 13, 6, 1'b0, 32'd0, 16);
    endtask

    // Sequential model of the table that follows taken branches
    task automatic run_model();
        int    pc;
        int    steps;
        data_t a;
        data_t b;
        data_t r;
        for (int i = 0; i < `OOO_NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        pc            = 0;
        steps         = 0;
        exp_commits   = 0;
        exp_redirects = 0;
        while (pc < NUM_INSTR && steps < 4 * NUM_INSTR) begin
            a = model_regs[prog[pc].rs1];
            b = prog[pc].use_imm ? prog[pc].imm : model_regs[prog[pc].rs2];
            if (prog[pc].op == OP_BR) begin
                r = prog[pc].iaddr + prog[pc].imm;
                if (a == model_regs[prog[pc].rs2]) begin
                    exp_target[exp_redirects] = r;
                    exp_redirects++;
                    pc = int'(r >> 2);
                end else begin
                    exp_wr[exp_commits] = 1'b0;
                    exp_commits++;
                    pc++;
                end
            end else begin
                case (prog[pc].func)
                    FUNC_ADD: r = a + b;
                    FUNC_SUB: r = a - b;
                    FUNC_AND: r = a & b;
                    default:  r = a ^ b;
                endcase
                model_regs[prog[pc].rd] = r;
                exp_wr[exp_commits]     = 1'b1;
                exp_rd[exp_commits]     = prog[pc].rd;
                exp_data[exp_commits]   = r;
                exp_commits++;
                pc++;
            end
            steps++;
        end
    endtask

    task automatic compare_value(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            errors++;
            $display("FAILED t=%0t %s: got 0x%0h expected 0x%0h", $time, name, got, exp);
        end
    endtask

    task automatic check_commit();
        if (commits_seen >= exp_commits) begin
            errors++;
            $display("Unexpected extra commit of r%0d at time %0t", commit.rd, $time);
        end else begin
            compare_value("o_commit.wr_en", data_t'(commit.wr_en), data_t'(exp_wr[commits_seen]));
            compare_value("o_commit.tag", data_t'(commit.tag), data_t'(exp_tag));
            // Branch commits carry no register result
            if (exp_wr[commits_seen]) begin
                compare_value("o_commit.rd", data_t'(commit.rd), data_t'(exp_rd[commits_seen]));
                compare_value("o_commit.data", commit.data, exp_data[commits_seen]);
            end
        end
        exp_tag = exp_tag + tag_t'(1);
        commits_seen++;
    endtask

    task automatic check_redirect();
        if (redirects_seen >= exp_redirects) begin
            errors++;
            $display("Unexpected redirect to 0x%0h at time %0t", redirect.target, $time);
        end else begin
            compare_value("o_redirect.target", redirect.target, exp_target[redirects_seen]);
        end
        // Allocation restarts just past the branch
        exp_tag = exp_tag + tag_t'(1);
        redirects_seen++;
    endtask

    // Falling edge view of what the next rising edge will do
    task automatic observe_cycle();
        seen_accept   = instr_valid && !stall;
        seen_redirect = redirect.en;
        seen_target   = redirect.target;
        if (instr_valid && stall) begin
            stall_cycles++;
        end
        if (commit.en) begin
            check_commit();
        end
        if (redirect.en) begin
            check_redirect();
        end
    endtask

    initial begin
        n_rst          = 1'b0;
        instr          = '0;
        instr_valid    = 1'b0;
        errors         = 0;
        commits_seen   = 0;
        redirects_seen = 0;
        stall_cycles   = 0;
        fetch_idx      = 0;
        cycles         = 0;
        seen_accept    = 1'b0;
        seen_redirect  = 1'b0;
        seen_target    = '0;
        exp_tag        = '0;
        rng            = 32'd33364;
        load_program();
        run_model();

        repeat (2) @(posedge clk);
        n_rst <= 1'b1;
        @(negedge clk);
        compare_value("o_stall", data_t'(stall), '0);
        compare_value("o_commit.en", data_t'(commit.en), '0);
        compare_value("o_redirect.en", data_t'(redirect.en), '0);

        while ((commits_seen < exp_commits || redirects_seen < exp_redirects) &&
               cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            if (seen_redirect) begin
                fetch_idx = int'(seen_target >> 2);
            end else if (seen_accept) begin
                fetch_idx++;
            end
            if (fetch_idx >= NUM_INSTR) begin
                instr_valid <= 1'b0;
            end else if (!(instr_valid && !seen_accept && !seen_redirect)) begin
                // Idle gaps fall only between instructions
                // A stalled instruction is held
                rng = lcg_next(rng);
                if (rng[17:16] == 2'b00) begin
                    instr_valid <= 1'b0;
                end else begin
                    instr_valid <= 1'b1;
                    instr       <= prog[fetch_idx];
                end
            end
            @(negedge clk);
            observe_cycle();
            cycles++;
        end
        if (cycles >= TIMEOUT_CYCLES) begin
            errors++;
            $display("Timeout: saw %0d of %0d commits and %0d of %0d redirects",
                     commits_seen, exp_commits, redirects_seen, exp_redirects);
        end

        // Let the pipe drain and catch late or duplicated results
        @(posedge clk);
        instr_valid <= 1'b0;
        for (int i = 0; i < DRAIN_CYCLES; i++) begin
            @(negedge clk);
            observe_cycle();
        end

        if (commits_seen != exp_commits) begin
            errors++;
            $display("Commit count is %0d but the model has %0d", commits_seen, exp_commits);
        end
        if (redirects_seen != exp_redirects) begin
            errors++;
            $display("Redirect count is %0d but the model has %0d", redirects_seen, exp_redirects);
        end
        if (stall_cycles == 0) begin
            errors++;
            $display("Stall never rose during the run");
        end
        // Skipped registers must still hold their model values
        for (int r = 0; r < `OOO_NUM_REGS; r++) begin
            compare_value($sformatf("regs[%0d]", r), ooo_core_i.rename_dispatch_i.regs[r],
                          model_regs[r]);
        end

        $display("Errors: %0d, commits: %0d, redirects: %0d, stall cycles: %0d",
                 errors, commits_seen, redirects_seen, stall_cycles);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+design
design/ooo_pkg.sv
design/reorder_buffer.sv
design/rename_dispatch.sv
design/alu_branch_unit.sv
design/ooo_core.sv
bench/ooo_core_tb.sv

/* Bender.yml */
package:
  name: ooo_core

sources:
  - include_dirs:
      - design
    files:
      - design/ooo_pkg.sv
      - design/reorder_buffer.sv
      - design/rename_dispatch.sv
      - design/alu_branch_unit.sv
      - design/ooo_core.sv
  - target: test
    include_dirs:
      - design
    files:
      - bench/ooo_core_tb.sv
